//--- rtl/sprite_pkg.sv
// Sprite display shared definitions
// Pixel, palette and color types, the command and state records passed
// between the control block and the sprite engines, and both palettes

package sprite_pkg;

    // Pixel coordinate, x or y
    typedef logic [9:0]  coord_t;
    // Palette index produced by sprite engines and the background
    typedef logic [3:0]  code_t;
    // 24-bit color, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    // Target of a sprite command
    typedef enum logic [1:0]
    {
        SPR_SHIP1 = 2'd0,
        SPR_SHIP2 = 2'd1,
        SPR_MENU  = 2'd2
    } sprite_id_t;

    // Command word on the valid/ready port, 23 bits
    typedef struct packed
    {
        sprite_id_t id;
        logic       enable;
        coord_t     pos_x;
        coord_t     pos_y;
    } sprite_cmd_t;

    // Committed per-sprite state, 21 bits
    typedef struct packed
    {
        logic   enable;
        coord_t pos_x;
        coord_t pos_y;
    } sprite_state_t;

    // Green key marks a see-through texel
    localparam rgb_t TRANSPARENT_KEY = 24'h00FF00;

    // Sky bands, three blues repeating
    localparam rgb_t BG_PALETTE [16] = '{
        24'h3FB9E9, 24'h0AA5E8, 24'h04A3E8, 24'h3FB9E9,
        24'h0AA5E8, 24'h04A3E8, 24'h3FB9E9, 24'h0AA5E8,
        24'h04A3E8, 24'h3FB9E9, 24'h0AA5E8, 24'h04A3E8,
        24'h3FB9E9, 24'h0AA5E8, 24'h04A3E8, 24'h3FB9E9
    };

    // Shared by both ships and the menu; entry 5 is the key
    localparam rgb_t SHIP_PALETTE [16] = '{
        24'hFFF3DC, 24'hCCC1D3, 24'hAE3F4C, 24'h9D834D,
        24'h020101, 24'h00FF00, 24'hF0CCAF, 24'hFFFBEB,
        24'h766C96, 24'hE3998A, 24'h59667F, 24'h535C74,
        24'hAB9B9E, 24'hDFE5EB, 24'h000000, 24'hFFFFFF
    };

endpackage

//--- rtl/vga_timing.sv
// VGA raster timing generator
// Scans one pixel per clock, decodes active-low sync pulses and the
// visible area, and flags the first pixel of every frame

`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import sprite_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
)
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    output coord_t      draw_x,
    output coord_t      draw_y,
    output logic        active,
    output logic        hsync,
    output logic        vsync,
    output logic        frame_start
);

    // Raster geometry
    localparam int     H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int     V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
    // Sync window starts right after the front porch
    localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t h_cnt;
    coord_t v_cnt;

    // ----------------------------------------------------------------------
    // Counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            // Counters come out of reset at (0,0), so that is a frame start
            frame_start <= 1'b1;
        end
        else
        begin
            // Next cycle shows (0,0) when both counters wrap together
            frame_start <= (h_cnt == H_LAST) && (v_cnt == V_LAST);
            if (h_cnt == H_LAST)
            begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + coord_t'(1);
            end
            else
            begin
                h_cnt <= h_cnt + coord_t'(1);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Decodes
    // ----------------------------------------------------------------------
    assign draw_x = h_cnt;
    assign draw_y = v_cnt;
    assign active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
    // Active low pulses
    assign hsync  = !((h_cnt >= HS_START) && (h_cnt < HS_END));
    assign vsync  = !((v_cnt >= VS_START) && (v_cnt < VS_END));

    // Frame strobe is predicted a cycle early, it must land on the origin
    a_frame_start_origin: assert property (
        @(posedge clk) disable iff (!arst_n)
        frame_start == ((draw_x == '0) && (draw_y == '0))
    );

endmodule

`default_nettype wire

//--- rtl/display_ctrl.sv
// Sprite command controller
// Takes position/enable commands over a valid/ready port and holds each
// one until the next frame start, so sprites only move between frames

`timescale 1ns/1ps
`default_nettype none

module display_ctrl
    import sprite_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        frame_start,
    input  wire logic        cmd_valid,
    input  wire sprite_cmd_t cmd,
    output logic             cmd_ready,
    output sprite_state_t    ship1_state,
    output sprite_state_t    ship2_state,
    output sprite_state_t    menu_state
);

    typedef enum logic [1:0]
    {
        CTRL_IDLE,
        CTRL_PENDING,
        CTRL_COMMIT
    } ctrl_state_t;

    ctrl_state_t ctrl_state;
    ctrl_state_t next_state;
    sprite_cmd_t cmd_hold;
    sprite_state_t new_state;
    logic        commit_en;

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    // One command in flight, no skid buffer
    assign cmd_ready = (ctrl_state == CTRL_IDLE);

    always_comb
    begin
        next_state = ctrl_state;
        case (ctrl_state)
            CTRL_IDLE:    if (cmd_valid) next_state = CTRL_PENDING;
            CTRL_PENDING: if (frame_start) next_state = CTRL_COMMIT;
            // New state is live this cycle, port reopens afterwards
            CTRL_COMMIT:  next_state = CTRL_IDLE;
            default:      next_state = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ctrl_state <= CTRL_IDLE;
        else
            ctrl_state <= next_state;
    end

    // Holding register, loaded on the handshake
    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
            cmd_hold <= cmd;
    end

    // ----------------------------------------------------------------------
    // Commit
    // ----------------------------------------------------------------------
    // Write on entry to COMMIT, visible the cycle after frame_start
    assign commit_en = (ctrl_state == CTRL_PENDING) && (next_state == CTRL_COMMIT);
    assign new_state = '{enable: cmd_hold.enable, pos_x: cmd_hold.pos_x,
                         pos_y: cmd_hold.pos_y};

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // All sprites start hidden
            ship1_state <= '0;
            ship2_state <= '0;
            menu_state  <= '0;
        end
        else if (commit_en)
        begin
            case (cmd_hold.id)
                SPR_SHIP1: ship1_state <= new_state;
                SPR_SHIP2: ship2_state <= new_state;
                SPR_MENU:  menu_state  <= new_state;
                // Unused id is dropped
                default:   ;
            endcase
        end
    end

    // Sender keeps the word steady until it is taken
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd))
    );

endmodule

`default_nettype wire

//--- rtl/sprite_engine.sv
// Sprite engine
// Tests whether the scanned pixel lies inside one square sprite and
// generates its texel code from a banded diagonal pattern, one stage deep

`timescale 1ns/1ps
`default_nettype none

module sprite_engine
    import sprite_pkg::*;
#(
    parameter int    SPRITE_SIZE  = 32,
    parameter code_t PATTERN_SEED = 4'd1
)
(
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire coord_t        draw_x,
    input  wire coord_t        draw_y,
    input  wire sprite_state_t state,
    output logic               hit,
    output code_t              code
);

    localparam coord_t SIZE = coord_t'(SPRITE_SIZE);

    // One extra bit so a pixel left of or above the sprite goes negative
    logic [10:0] dx;
    logic [10:0] dy;
    coord_t      local_x;
    coord_t      local_y;
    logic        in_x;
    logic        in_y;
    logic        hit_next;
    code_t       band_x;
    code_t       band_y;
    code_t       texel;

    // ----------------------------------------------------------------------
    // Hit test
    // ----------------------------------------------------------------------
    assign dx      = {1'b0, draw_x} - {1'b0, state.pos_x};
    assign dy      = {1'b0, draw_y} - {1'b0, state.pos_y};
    assign local_x = dx[9:0];
    assign local_y = dy[9:0];

    // Sign bit clear and inside the square
    assign in_x     = !dx[10] && (local_x < SIZE);
    assign in_y     = !dy[10] && (local_y < SIZE);
    assign hit_next = state.enable && in_x && in_y;

    // ----------------------------------------------------------------------
    // Texel pattern
    // ----------------------------------------------------------------------
    // 4x4 pixel cells, code steps by one per cell along x and along y
    // Only the low four bits of each cell index matter modulo 16
    assign band_x = local_x[5:2];
    assign band_y = local_y[5:2];
    // Wraps naturally in four bits
    assign texel  = band_x + band_y + PATTERN_SEED;

    // ----------------------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hit  <= 1'b0;
            code <= '0;
        end
        else
        begin
            hit  <= hit_next;
            // Zero code away from the sprite keeps the bus quiet
            code <= hit_next ? texel : '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/color_mapper.sv
// Color mapper
// Looks up sprite and background codes in the palettes, applies the
// transparent key and layer priority, and registers the RGB pixel

`timescale 1ns/1ps
`default_nettype none

module color_mapper
    import sprite_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   active,
    input  wire logic   hsync,
    input  wire logic   vsync,
    input  wire coord_t x_in,
    input  wire coord_t y_in,
    input  wire logic   menu_hit,
    input  wire logic   ship1_hit,
    input  wire logic   ship2_hit,
    input  wire code_t  menu_code,
    input  wire code_t  ship1_code,
    input  wire code_t  ship2_code,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        out_hsync,
    output logic        out_vsync,
    output logic        pixel_valid,
    output coord_t      out_x,
    output coord_t      out_y
);

    rgb_t bg_color;
    rgb_t menu_color;
    rgb_t ship1_color;
    rgb_t ship2_color;
    rgb_t pix_color;

    // ----------------------------------------------------------------------
    // Palette lookup and priority
    // ----------------------------------------------------------------------
    // Background bands are four rows tall
    assign bg_color    = BG_PALETTE[y_in[5:2]];
    assign menu_color  = SHIP_PALETTE[menu_code];
    assign ship1_color = SHIP_PALETTE[ship1_code];
    assign ship2_color = SHIP_PALETTE[ship2_code];

    // Menu over ship one over ship two over sky
    // A keyed texel falls through to the next layer down
    always_comb
    begin
        if (!active)
            pix_color = '0;
        else if (menu_hit && (menu_color != TRANSPARENT_KEY))
            pix_color = menu_color;
        else if (ship1_hit && (ship1_color != TRANSPARENT_KEY))
            pix_color = ship1_color;
        else if (ship2_hit && (ship2_color != TRANSPARENT_KEY))
            pix_color = ship2_color;
        else
            pix_color = bg_color;
    end

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            {vga_r, vga_g, vga_b} <= '0;
            // Syncs idle high
            out_hsync   <= 1'b1;
            out_vsync   <= 1'b1;
            pixel_valid <= 1'b0;
        end
        else
        begin
            {vga_r, vga_g, vga_b} <= pix_color;
            out_hsync   <= hsync;
            out_vsync   <= vsync;
            pixel_valid <= active;
        end
    end

    // Coordinates ride alongside the color
    always_ff @(posedge clk)
    begin
        out_x <= x_in;
        out_y <= y_in;
    end

endmodule

`default_nettype wire

//--- rtl/display_top.sv
// Sprite display top level
// Raster timing, sprite command control, three sprite engines and the
// color mapper; outputs trail the counters by two clocks

`timescale 1ns/1ps
`default_nettype none

module display_top
    import sprite_pkg::*;
#(
    parameter int    H_ACTIVE   = 640,
    parameter int    H_FRONT    = 16,
    parameter int    H_SYNC     = 96,
    parameter int    H_BACK     = 48,
    parameter int    V_ACTIVE   = 480,
    parameter int    V_FRONT    = 10,
    parameter int    V_SYNC     = 2,
    parameter int    V_BACK     = 33,
    parameter int    SHIP_SIZE  = 32,
    parameter int    MENU_SIZE  = 64,
    parameter code_t SHIP1_SEED = 4'd1,
    parameter code_t SHIP2_SEED = 4'd7,
    parameter code_t MENU_SEED  = 4'd12
)
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        cmd_valid,
    input  wire sprite_cmd_t cmd,
    output logic             cmd_ready,
    output logic [7:0]       vga_r,
    output logic [7:0]       vga_g,
    output logic [7:0]       vga_b,
    output logic             hsync,
    output logic             vsync,
    output logic             pixel_valid,
    output coord_t           out_x,
    output coord_t           out_y
);

    coord_t        draw_x, draw_y;
    logic          tim_active, tim_hsync, tim_vsync, frame_start;
    sprite_state_t ship1_state, ship2_state, menu_state;
    logic          ship1_hit, ship2_hit, menu_hit;
    code_t         ship1_code, ship2_code, menu_code;
    // Timing signals aligned with the sprite engine stage
    logic          active_d, hsync_d, vsync_d;
    coord_t        x_d, y_d;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) timing_i (
        .clk (clk), .arst_n (arst_n), .draw_x (draw_x), .draw_y (draw_y),
        .active (tim_active), .hsync (tim_hsync), .vsync (tim_vsync),
        .frame_start (frame_start)
    );

    display_ctrl ctrl_i (
        .clk (clk), .arst_n (arst_n), .frame_start (frame_start),
        .cmd_valid (cmd_valid), .cmd (cmd), .cmd_ready (cmd_ready),
        .ship1_state (ship1_state), .ship2_state (ship2_state), .menu_state (menu_state)
    );

    // ----------------------------------------------------------------------
    // Sprite engines
    // ----------------------------------------------------------------------
    sprite_engine #(.SPRITE_SIZE (SHIP_SIZE), .PATTERN_SEED (SHIP1_SEED)) ship1_i (
        .clk (clk), .arst_n (arst_n), .draw_x (draw_x), .draw_y (draw_y),
        .state (ship1_state), .hit (ship1_hit), .code (ship1_code)
    );

    sprite_engine #(.SPRITE_SIZE (SHIP_SIZE), .PATTERN_SEED (SHIP2_SEED)) ship2_i (
        .clk (clk), .arst_n (arst_n), .draw_x (draw_x), .draw_y (draw_y),
        .state (ship2_state), .hit (ship2_hit), .code (ship2_code)
    );

    // Choose-state overlay
    sprite_engine #(.SPRITE_SIZE (MENU_SIZE), .PATTERN_SEED (MENU_SEED)) menu_i (
        .clk (clk), .arst_n (arst_n), .draw_x (draw_x), .draw_y (draw_y),
        .state (menu_state), .hit (menu_hit), .code (menu_code)
    );

    // ----------------------------------------------------------------------
    // Alignment stage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end
        else
        begin
            active_d <= tim_active;
            hsync_d  <= tim_hsync;
            vsync_d  <= tim_vsync;
        end
    end

    always_ff @(posedge clk)
    begin
        x_d <= draw_x;
        y_d <= draw_y;
    end

    color_mapper mapper_i (
        .clk (clk), .arst_n (arst_n), .active (active_d), .hsync (hsync_d),
        .vsync (vsync_d), .x_in (x_d), .y_in (y_d),
        .menu_hit (menu_hit), .ship1_hit (ship1_hit), .ship2_hit (ship2_hit),
        .menu_code (menu_code), .ship1_code (ship1_code), .ship2_code (ship2_code),
        .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
        .out_hsync (hsync), .out_vsync (vsync), .pixel_valid (pixel_valid),
        .out_x (out_x), .out_y (out_y)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Testbench clock source
// Free-running clock, 10 ns period, starts low

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
    parameter int HALF_PERIOD_NS = 5
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- test/tb_display_top.sv
// Sprite display testbench
// Drives sprite commands into a reduced raster, models the committed
// sprite state and checks every output pixel, sync and handshake

`timescale 1ns/1ps
`default_nettype none

module tb_display_top
    import sprite_pkg::*;
();

    // Small frame, 80 x 54 clocks
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;
    localparam int SHIP_SIZE = 32;
    localparam int MENU_SIZE = 64;
    localparam rgb_t KEY_COLOR = 24'h00FF00;

    logic          clk;
    logic          arst_n;
    logic          cmd_valid;
    sprite_cmd_t   cmd;
    logic          cmd_ready;
    logic [7:0]    vga_r, vga_g, vga_b;
    logic          hsync, vsync, pixel_valid;
    coord_t        out_x, out_y;

    // Reference model state, as seen by the pixel now on the outputs
    sprite_state_t m_ship1, m_ship2, m_menu;
    sprite_cmd_t   pend_cmd;
    logic          pend_valid;
    logic          commit_now;
    logic          in_area;
    logic          checks_on = 1'b0;
    rgb_t          exp_rgb;
    int            cycle_cnt;
    int            accept_cnt;
    int            rst_cycles = 0;
    int            rand_seed;
    int            pixel_errs = 0;
    int            sync_errs = 0;
    int            raster_errs = 0;
    int            hs_errs = 0;
    int            timeout_errs = 0;

    tb_clock_gen clk_gen_i (.clk (clk));

    display_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) dut_i (
        .clk (clk), .arst_n (arst_n), .cmd_valid (cmd_valid), .cmd (cmd),
        .cmd_ready (cmd_ready), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
        .hsync (hsync), .vsync (vsync), .pixel_valid (pixel_valid),
        .out_x (out_x), .out_y (out_y)
    );

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic logic covers(coord_t x, coord_t y, sprite_state_t s, int size);
        int lx;
        int ly;
        lx = int'(x) - int'(s.pos_x);
        ly = int'(y) - int'(s.pos_y);
        return s.enable && (lx >= 0) && (lx < size) && (ly >= 0) && (ly < size);
    endfunction

    // 4x4 cells, code climbs one per cell in x and in y, plus the seed
    function automatic rgb_t texel_color(coord_t x, coord_t y, sprite_state_t s, int pat_seed);
        int band;
        band = (int'(x) - int'(s.pos_x)) / 4 + (int'(y) - int'(s.pos_y)) / 4 + pat_seed;
        // Modulo 16 by the low four bits
        return SHIP_PALETTE[band[3:0]];
    endfunction

    function automatic rgb_t expected_rgb(coord_t x, coord_t y, sprite_state_t s1,
                                          sprite_state_t s2, sprite_state_t mn);
        rgb_t c;
        // Menu first, then ship one, then ship two; a keyed texel falls through
        if (covers(x, y, mn, MENU_SIZE))
        begin
            c = texel_color(x, y, mn, 12);
            if (c != KEY_COLOR)
                return c;
        end
        if (covers(x, y, s1, SHIP_SIZE))
        begin
            c = texel_color(x, y, s1, 1);
            if (c != KEY_COLOR)
                return c;
        end
        if (covers(x, y, s2, SHIP_SIZE))
        begin
            c = texel_color(x, y, s2, 7);
            if (c != KEY_COLOR)
                return c;
        end
        // Sky band changes every four rows
        return BG_PALETTE[y[5:2]];
    endfunction

    function automatic sprite_state_t held_state(sprite_cmd_t c);
        sprite_state_t s;
        s.enable = c.enable;
        s.pos_x  = c.pos_x;
        s.pos_y  = c.pos_y;
        return s;
    endfunction

    always_comb
        exp_rgb = expected_rgb(out_x, out_y, m_ship1, m_ship2, m_menu);

    // Visible area as given by the coordinates on the outputs
    assign in_area = (out_x < coord_t'(H_ACTIVE)) && (out_y < coord_t'(V_ACTIVE));

    // Origin pixel on the outputs marks a frame start two clocks back
    // Needs a full cycle of pending before that start to take effect
    assign commit_now = pend_valid && (out_x == '0) && (out_y == '0)
                        && (cycle_cnt >= accept_cnt + 3);

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            m_ship1    <= '0;
            m_ship2    <= '0;
            m_menu     <= '0;
            pend_cmd   <= '0;
            pend_valid <= 1'b0;
            cycle_cnt  <= 0;
            accept_cnt <= 0;
            checks_on  <= 1'b0;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 1;
            // Pipeline is full after a few clocks
            if (cycle_cnt == 4)
                checks_on <= 1'b1;
            // Origin pixel still shows the old state, the next one the new
            if (commit_now)
            begin
                case (pend_cmd.id)
                    SPR_SHIP1: m_ship1 <= held_state(pend_cmd);
                    SPR_SHIP2: m_ship2 <= held_state(pend_cmd);
                    SPR_MENU:  m_menu  <= held_state(pend_cmd);
                    default:   ;
                endcase
                pend_valid <= 1'b0;
            end
            if (cmd_valid && cmd_ready)
            begin
                pend_cmd   <= cmd;
                accept_cnt <= cycle_cnt;
                pend_valid <= 1'b1;
            end
        end
    end

    always @(posedge clk)
    begin
        if (!arst_n)
            rst_cycles <= rst_cycles + 1;
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    a_pixel_rgb: assert property (@(posedge clk) disable iff (!checks_on)
        {vga_r, vga_g, vga_b} == (in_area ? exp_rgb : 24'h0))
    else
    begin
        pixel_errs++;
        $display("[FAIL] %0t pixel (%0d,%0d) rgb %06h, expected %06h", $time,
                 $sampled(out_x), $sampled(out_y),
                 $sampled({vga_r, vga_g, vga_b}), $sampled(exp_rgb));
    end

    a_active_area: assert property (@(posedge clk) disable iff (!checks_on)
        pixel_valid == in_area)
    else
    begin
        raster_errs++;
        $display("[FAIL] %0t pixel_valid wrong at (%0d,%0d)", $time,
                 $sampled(out_x), $sampled(out_y));
    end

    // Sync windows must line up with the coordinates beside them
    a_hsync: assert property (@(posedge clk) disable iff (!checks_on)
        hsync == !((int'(out_x) >= HS_START) && (int'(out_x) < HS_END)))
    else
    begin
        sync_errs++;
        $display("[FAIL] %0t hsync %0b at x %0d", $time, $sampled(hsync), $sampled(out_x));
    end

    a_vsync: assert property (@(posedge clk) disable iff (!checks_on)
        vsync == !((int'(out_y) >= VS_START) && (int'(out_y) < VS_END)))
    else
    begin
        sync_errs++;
        $display("[FAIL] %0t vsync %0b at y %0d", $time, $sampled(vsync), $sampled(out_y));
    end

    a_x_step: assert property (@(posedge clk) disable iff (!checks_on)
        out_x == coord_t'((int'($past(out_x)) + 1) % H_TOTAL))
    else
    begin
        raster_errs++;
        $display("[FAIL] %0t out_x jumped to %0d", $time, $sampled(out_x));
    end

    a_y_step: assert property (@(posedge clk) disable iff (!checks_on)
        out_y == (($past(out_x) == coord_t'(H_TOTAL - 1))
                  ? coord_t'((int'($past(out_y)) + 1) % V_TOTAL) : $past(out_y)))
    else
    begin
        raster_errs++;
        $display("[FAIL] %0t out_y jumped to %0d", $time, $sampled(out_y));
    end

    // Back-pressure holds until the frame start takes the command
    a_ready_low: assert property (@(posedge clk) disable iff (!checks_on)
        (pend_valid && !commit_now) |-> !cmd_ready)
    else
    begin
        hs_errs++;
        $display("[FAIL] %0t cmd_ready high with a command pending", $time);
    end

    a_ready_back: assert property (@(posedge clk) disable iff (!checks_on)
        commit_now |-> cmd_ready)
    else
    begin
        hs_errs++;
        $display("[FAIL] %0t cmd_ready still low after the frame start", $time);
    end

    a_reset_values: assert property (@(posedge clk) disable iff (arst_n)
        (rst_cycles >= 2) |-> (cmd_ready && !pixel_valid && hsync && vsync
                               && ({vga_r, vga_g, vga_b} == 24'h0)))
    else
    begin
        hs_errs++;
        $display("[FAIL] %0t outputs not at their reset values", $time);
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    task automatic report_timeout(input string what);
        timeout_errs++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    task automatic send_cmd(input sprite_cmd_t c);
        int waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        @(posedge clk);
        cmd       <= c;
        cmd_valid <= 1'b1;
        while (!taken && (waited <= 3 * FRAME_CYCLES))
        begin
            @(posedge clk);
            waited++;
            taken = cmd_ready;
        end
        cmd_valid <= 1'b0;
        if (!taken)
            report_timeout("command was never accepted");
    endtask

    task automatic wait_frames(input int n);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while ((seen < n) && (waited <= (n + 1) * FRAME_CYCLES))
        begin
            @(posedge clk);
            waited++;
            if (pixel_valid && (out_x == '0) && (out_y == '0))
                seen++;
        end
        if (seen < n)
            report_timeout("no frame start seen on the outputs");
    endtask

    task automatic random_cmd(input sprite_id_t id, output sprite_cmd_t c);
        int r;
        r        = $random(rand_seed);
        c.id     = id;
        c.enable = 1'b1;
        c.pos_x  = coord_t'(r[5:0]);
        c.pos_y  = coord_t'(r[21:16] % 48);
    endtask

    initial
    begin
        sprite_cmd_t c1;
        sprite_cmd_t c2;
        sprite_cmd_t c3;
        int r;
        rand_seed = 32'hcaa4f7e7;
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // Sky only
        wait_frames(2);

        // Ship one, kept up and left so the other layers fit beside it
        random_cmd(SPR_SHIP1, c1);
        c1.pos_x = c1.pos_x >> 1;
        c1.pos_y = c1.pos_y >> 1;
        send_cmd(c1);
        wait_frames(2);

        // Ship two under the keyed cells of ship one
        // Menu queued behind it while it is pending
        c2       = c1;
        c2.id    = SPR_SHIP2;
        c2.pos_x = c1.pos_x + coord_t'(8);
        c2.pos_y = c1.pos_y + coord_t'(6);
        c3       = c1;
        c3.id    = SPR_MENU;
        c3.pos_x = c1.pos_x + coord_t'(20);
        c3.pos_y = c1.pos_y + coord_t'(18);
        send_cmd(c2);
        send_cmd(c3);
        wait_frames(2);

        // Moves accepted at random points in the frame
        repeat (3)
        begin
            r = $random(rand_seed);
            repeat (r[11:0]) @(posedge clk);
            random_cmd(SPR_SHIP1, c1);
            send_cmd(c1);
        end
        wait_frames(2);

        // Hide everything again
        c3.enable = 1'b0;
        send_cmd(c3);
        c1.enable = 1'b0;
        send_cmd(c1);
        c2.enable = 1'b0;
        send_cmd(c2);
        wait_frames(2);

        $display("Errors: pixel=%0d sync=%0d raster=%0d handshake=%0d timeout=%0d",
                 pixel_errs, sync_errs, raster_errs, hs_errs, timeout_errs);
        if ((pixel_errs + sync_errs + raster_errs + hs_errs + timeout_errs) == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/sprite_pkg.sv
rtl/vga_timing.sv
rtl/display_ctrl.sv
rtl/sprite_engine.sv
rtl/color_mapper.sv
rtl/display_top.sv
test/tb_clock_gen.sv
test/tb_display_top.sv

//--- Makefile
# Verilator build and run for the sprite display testbench

VERILATOR ?= verilator
TOP       ?= tb_display_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: no pass line in log"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
